// File: Bender.yml
package:
  name: lsu

sources:
  - files:
      - logic/lsu_pkg.sv
      - logic/lsu_access_if.sv
      - logic/lsu_req_gen.sv
      - logic/lsu_rdata_align.sv
      - logic/lsu_ctrl_fsm.sv
      - logic/lsu_top.sv
  - target: test
    files:
      - dv/tb_lsu.sv

// File: dv/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

  localparam int unsigned TIMEOUT = 20;  // cycles allowed for any wait

  logic                              clk;
  logic                              rst_n;
  logic                              data_req_o;
  logic                              data_gnt_i;
  logic                              data_rvalid_i;
  logic [lsu_pkg::DATA_W-1:0]        data_addr_o;
  logic                              data_we_o;
  logic [lsu_pkg::BE_W-1:0]          data_be_o;
  logic [lsu_pkg::DATA_W-1:0]        data_wdata_o;
  logic [lsu_pkg::DATA_W-1:0]        data_rdata_i;
  logic                              data_we_ex_i;
  logic [lsu_pkg::TYPE_W-1:0]        data_type_ex_i;
  logic [lsu_pkg::DATA_W-1:0]        data_wdata_ex_i;
  logic [lsu_pkg::OFF_W-1:0]         data_reg_offset_ex_i;
  logic [lsu_pkg::SEXT_W-1:0]        data_sign_ext_ex_i;
  logic [lsu_pkg::DATA_W-1:0]        data_rdata_ex_o;
  logic                              data_req_ex_i;
  logic [lsu_pkg::DATA_W-1:0]        operand_a_ex_i;
  logic [lsu_pkg::DATA_W-1:0]        operand_b_ex_i;
  logic                              addr_useincr_ex_i;
  logic                              data_misaligned_ex_i;
  logic                              data_misaligned_o;
  logic                              lsu_ready_ex_o;
  logic                              lsu_ready_wb_o;
  logic                              ex_valid_i;
  logic                              busy_o;

  logic [31:0]                       lfsr;      // random source stepped once per bit
  logic [lsu_pkg::DATA_W-1:0]        mem [16];  // word memory indexed by addr[5:2]

  lsu_top i_lsu_top (.*);

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int unsigned i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string what, input logic [lsu_pkg::DATA_W-1:0] got, exp);
    if (got !== exp)
      stop_run($sformatf("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_be(input string what, input logic [lsu_pkg::BE_W-1:0] got, exp);
    if (got !== exp)
      stop_run($sformatf("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_bit(input string what, input logic got, exp);
    if (got !== exp)
      stop_run($sformatf("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;                                          // drive point
  endtask

  // a + b or a alone
  function automatic logic [lsu_pkg::DATA_W-1:0] expected_addr();
    return addr_useincr_ex_i ? operand_a_ex_i + operand_b_ex_i : operand_a_ex_i;
  endfunction

  function automatic logic is_split(input logic [lsu_pkg::TYPE_W-1:0] t,
                                    input logic [lsu_pkg::OFF_W-1:0] off);
    return ((t == lsu_pkg::TYPE_WORD) && (off != 0)) || ((t == lsu_pkg::TYPE_HALF) && (off == 3));
  endfunction

  // first part shifts the type mask to the offset and a second part takes the lanes below it
  function automatic logic [lsu_pkg::BE_W-1:0] expected_be(input logic [lsu_pkg::TYPE_W-1:0] t,
                                                           input logic [lsu_pkg::OFF_W-1:0] off,
                                                           input logic second);
    logic [lsu_pkg::BE_W-1:0] full;
    full = (t == lsu_pkg::TYPE_WORD) ? 4'b1111 : (t == lsu_pkg::TYPE_HALF) ? 4'b0011 : 4'b0001;
    if (!second)
      return full << off;
    else if (t == lsu_pkg::TYPE_WORD)
      return (4'b0001 << off) - 4'b0001;
    else
      return 4'b0001;
  endfunction

  // lane l gets register byte l - k
  function automatic logic [lsu_pkg::DATA_W-1:0] rotate_lanes(input logic [lsu_pkg::DATA_W-1:0] w,
                                                              input logic [lsu_pkg::OFF_W-1:0] k);
    logic [lsu_pkg::DATA_W-1:0] r;
    logic [lsu_pkg::OFF_W-1:0]  src;
    for (int l = 0; l < 4; l++)
    begin
      src          = l[1:0] - k;
      r[8*l +: 8]  = w[8*src +: 8];
    end
    return r;
  endfunction

  // bytes from offset on in {hi, lo} and then extended
  function automatic logic [lsu_pkg::DATA_W-1:0] expected_load(
    input logic [lsu_pkg::DATA_W-1:0] lo, hi,
    input logic [lsu_pkg::TYPE_W-1:0] t,
    input logic [lsu_pkg::OFF_W-1:0]  off,
    input logic [lsu_pkg::SEXT_W-1:0] sext);
    logic [63:0]                pair;
    logic [lsu_pkg::DATA_W-1:0] top;
    int unsigned                sh;
    pair = {hi, lo} >> (8 * off);
    sh   = (t == lsu_pkg::TYPE_WORD) ? 0 : (t == lsu_pkg::TYPE_HALF) ? 16 : 24;
    top  = pair[31:0] << sh;                     // field msb at bit 31
    case (sext)
      lsu_pkg::SEXT_ZERO: return top >> sh;
      lsu_pkg::SEXT_ONES: return ~((~top) >> sh);
      default:            return $signed(top) >>> sh;
    endcase
  endfunction

  task automatic set_addr(input logic [lsu_pkg::OFF_W-1:0] off, input logic inc);
    logic [lsu_pkg::DATA_W-1:0] a;
    logic [lsu_pkg::DATA_W-1:0] b;
    a = rand_bits(32);
    b = rand_bits(32);
    if (inc)
      b[1:0] = off - a[1:0];                     // sum lands on off
    else
      a[1:0] = off;
    operand_a_ex_i    = a;
    operand_b_ex_i    = b;
    addr_useincr_ex_i = inc;
  endtask

  ////////////////////////////////////////////////////////////
  // memory responder
  ////////////////////////////////////////////////////////////

  // one access with random grant and rvalid delays that returns rdata_ex seen on rvalid
  task automatic run_access(input logic second_follows,
                            output logic [lsu_pkg::DATA_W-1:0] result);
    int unsigned                gnt_dly;
    int unsigned                rv_dly;
    logic [lsu_pkg::DATA_W-1:0] word;
    logic [lsu_pkg::DATA_W-1:0] next_addr;
    gnt_dly       = rand_bits(2) % 3;            // 0..2 cycles
    rv_dly        = rand_bits(2) % 3 + 1;        // 1..3 cycles after grant
    data_req_ex_i = 1'b1;
    for (int unsigned n = 0; n < gnt_dly; n++)
    begin
      #1;
      check_bit("lsu_ready_ex_o with grant withheld", lsu_ready_ex_o, 1'b0);
      check_bit("busy_o with grant withheld", busy_o, 1'b1);
      next_cycle();
    end
    data_gnt_i = 1'b1;
    #1;
    check_bit("data_req_o at grant", data_req_o, 1'b1);
    check_bit("lsu_ready_ex_o at grant", lsu_ready_ex_o, 1'b1);
    word      = mem[data_addr_o[5:2]];
    next_addr = expected_addr() + 4;             // same offset in the next word
    next_cycle();
    data_gnt_i = 1'b0;
    if (second_follows)
    begin
      operand_a_ex_i       = next_addr;          // EX moves to the second part
      addr_useincr_ex_i    = 1'b0;
      data_misaligned_ex_i = 1'b1;
    end
    else
    begin
      data_req_ex_i        = 1'b0;
      data_misaligned_ex_i = 1'b0;
    end
    for (int unsigned n = 1; n < rv_dly; n++)
    begin
      #1;
      check_bit("lsu_ready_wb_o before rvalid", lsu_ready_wb_o, 1'b0);
      check_bit("data_req_o before rvalid", data_req_o, 1'b0);
      next_cycle();
    end
    data_rvalid_i = 1'b1;
    data_rdata_i  = word;
    #1;
    check_bit("lsu_ready_wb_o on rvalid", lsu_ready_wb_o, 1'b1);
    result = data_rdata_ex_o;
    next_cycle();
    data_rvalid_i = 1'b0;
    data_rdata_i  = rand_bits(32);               // bus data no longer valid
  endtask

  // first part and then the second with the misaligned flag set
  task automatic split_access(output logic [lsu_pkg::DATA_W-1:0] result);
    logic [lsu_pkg::DATA_W-1:0] first;
    #1;
    check_bit("data_misaligned_o on first part", data_misaligned_o, 1'b1);
    next_cycle();
    run_access(1'b1, first);
    #1;
    check_bit("data_misaligned_o on second part", data_misaligned_o, 1'b0);
    check_be("second part byte enables", data_be_o,
             expected_be(data_type_ex_i, operand_a_ex_i[1:0], 1'b1));  // a alone here
    next_cycle();
    run_access(1'b0, result);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic store_sweep();
    logic [lsu_pkg::DATA_W-1:0] res;
    data_we_ex_i = 1'b1;
    for (int t = 0; t < 3; t++)                  // word, half, byte
      for (int off = 0; off < 4; off++)
        for (int roff = 0; roff < 4; roff++)
          for (int inc = 0; inc < 2; inc++)
          begin
            set_addr(off[1:0], inc[0]);
            data_type_ex_i       = t[1:0];
            data_reg_offset_ex_i = roff[1:0];
            data_wdata_ex_i      = rand_bits(32);
            data_req_ex_i        = 1'b1;
            #1;
            check_word("store address", data_addr_o, expected_addr());
            check_be("store byte enables", data_be_o, expected_be(t[1:0], off[1:0], 1'b0));
            check_word("store data", data_wdata_o,
                       rotate_lanes(data_wdata_ex_i, off[1:0] - roff[1:0]));
            check_bit("data_we_o", data_we_o, 1'b1);
            check_bit("data_misaligned_o", data_misaligned_o, is_split(t[1:0], off[1:0]));
            if (is_split(t[1:0], off[1:0]))
              split_access(res);
            else
            begin
              next_cycle();
              run_access(1'b0, res);
            end
          end
  endtask

  // one load checked on rvalid and one cycle later
  task automatic load_once(input logic [lsu_pkg::TYPE_W-1:0] t, input logic [1:0] off,
                           input logic [lsu_pkg::SEXT_W-1:0] sext);
    logic [lsu_pkg::DATA_W-1:0] addr;
    logic [lsu_pkg::DATA_W-1:0] exp;
    logic [lsu_pkg::DATA_W-1:0] res;
    logic [3:0]                 idx;
    set_addr(off, rand_bits(1));
    data_we_ex_i         = 1'b0;
    data_type_ex_i       = t;
    data_sign_ext_ex_i   = sext;
    data_reg_offset_ex_i = '0;
    data_req_ex_i        = 1'b1;
    addr = expected_addr();
    idx  = addr[5:2];
    exp  = expected_load(mem[idx], mem[idx + 4'd1], t, off, sext);
    #1;
    check_bit("data_we_o on load", data_we_o, 1'b0);
    if (is_split(t, off))
      split_access(res);
    else
      run_access(1'b0, res);
    check_word("load result on rvalid", res, exp);
    #1;
    check_word("held load result", data_rdata_ex_o, exp);
    next_cycle();
  endtask

  task automatic aligned_loads();
    for (int t = 0; t < 3; t++)
      for (int off = 0; off < 4; off++)
        for (int sext = 0; sext < 4; sext++)
          if (!is_split(t[1:0], off[1:0]))
            load_once(t[1:0], off[1:0], sext[1:0]);
  endtask

  task automatic misaligned_loads();
    for (int off = 1; off < 4; off++)
      load_once(lsu_pkg::TYPE_WORD, off[1:0], lsu_pkg::SEXT_ZERO);
    for (int sext = 0; sext < 4; sext++)
      load_once(lsu_pkg::TYPE_HALF, 2'd3, sext[1:0]);  // crosses into the next word
  endtask

  // grant arrives while EX is stalled and EX keeps its next request up
  task automatic ex_stall_flow();
    logic [lsu_pkg::DATA_W-1:0] addr;
    logic [lsu_pkg::DATA_W-1:0] exp;
    logic [3:0]                 idx;
    int unsigned                n;
    set_addr(2'd2, 1'b1);
    data_we_ex_i       = 1'b0;
    data_type_ex_i     = 2'b10;                  // byte
    data_sign_ext_ex_i = 2'd1;                   // sign
    data_req_ex_i      = 1'b1;
    ex_valid_i         = 1'b0;
    data_gnt_i         = 1'b1;
    addr = expected_addr();
    idx  = addr[5:2];
    exp  = expected_load(mem[idx], mem[idx + 4'd1], 2'b10, 2'd2, 2'd1);
    #1;
    check_bit("data_req_o at stalled grant", data_req_o, 1'b1);
    next_cycle();
    data_gnt_i = 1'b0;
    #1;
    check_bit("data_req_o during EX stall", data_req_o, 1'b0);
    check_bit("busy_o during EX stall", busy_o, 1'b1);
    next_cycle();
    data_rvalid_i = 1'b1;
    data_rdata_i  = mem[idx];
    #1;
    check_bit("data_req_o on stalled rvalid", data_req_o, 1'b0);
    check_word("load result on stalled rvalid", data_rdata_ex_o, exp);
    next_cycle();
    data_rvalid_i = 1'b0;
    data_rdata_i  = rand_bits(32);
    for (int k = 0; k < 3; k++)
    begin
      #1;
      check_bit("data_req_o after rvalid in EX stall", data_req_o, 1'b0);
      check_bit("busy_o after rvalid in EX stall", busy_o, 1'b1);
      check_word("held result in EX stall", data_rdata_ex_o, exp);
      next_cycle();
    end
    ex_valid_i    = 1'b1;                        // EX moves on without a memory op
    data_req_ex_i = 1'b0;
    n = 0;
    #1;
    while (busy_o && (n < TIMEOUT))
    begin
      next_cycle();
      #1;
      n++;
    end
    if (busy_o)
      stop_run("timeout: busy_o stayed high after the EX stall ended");
    check_word("held result after EX stall", data_rdata_ex_o, exp);
    next_cycle();
  endtask

  initial
  begin
    clk                  = 1'b0;
    rst_n                = 1'b0;
    lfsr                 = 32'h6e05;
    data_gnt_i           = 1'b0;
    data_rvalid_i        = 1'b0;
    data_rdata_i         = '0;
    data_we_ex_i         = 1'b0;
    data_type_ex_i       = lsu_pkg::TYPE_WORD;
    data_wdata_ex_i      = '0;
    data_reg_offset_ex_i = '0;
    data_sign_ext_ex_i   = lsu_pkg::SEXT_ZERO;
    data_req_ex_i        = 1'b0;
    operand_a_ex_i       = '0;
    operand_b_ex_i       = '0;
    addr_useincr_ex_i    = 1'b0;
    data_misaligned_ex_i = 1'b0;
    ex_valid_i           = 1'b1;
    for (int i = 0; i < 16; i++)
      mem[i] = rand_bits(32);
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    #1;
    check_bit("data_req_o after reset", data_req_o, 1'b0);
    check_bit("busy_o after reset", busy_o, 1'b0);
    check_bit("lsu_ready_ex_o after reset", lsu_ready_ex_o, 1'b1);
    check_bit("lsu_ready_wb_o after reset", lsu_ready_wb_o, 1'b1);
    next_cycle();
    store_sweep();
    aligned_loads();
    misaligned_loads();
    ex_stall_flow();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: logic/lsu_access_if.sv
`timescale 1ns/1ps

// context of the access that is on the bus right now
interface lsu_access_if;

  logic [lsu_pkg::TYPE_W-1:0] data_type;      // word, half or byte
  logic [lsu_pkg::OFF_W-1:0]  offset;         // low address bits
  logic [lsu_pkg::SEXT_W-1:0] sign_ext;       // extension mode from EX
  logic                       we;             // store when high
  logic                       split_pending;  // some part of a split access is running

  // request side fills the context
  modport req
  (
    output data_type, offset, sign_ext, we, split_pending
  );

  // read data side consumes it
  modport align
  (
    input  data_type, offset, sign_ext, we, split_pending
  );

endinterface

// File: logic/lsu_ctrl_fsm.sv
`timescale 1ns/1ps

module lsu_ctrl_fsm
(
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,   // EX wants a memory access
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic ex_valid_i,      // EX stage completes this cycle
  output logic data_req_o,      // request to memory
  output logic lsu_ready_ex_o,
  output logic lsu_ready_wb_o,
  output logic busy_o
);

  typedef enum logic [1:0]
  {
    IDLE,
    WAIT_RVALID,
    WAIT_RVALID_EX_STALL,
    IDLE_EX_STALL
  } state_e;

  state_e state_q;
  state_e state_d;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      IDLE:
      begin
        data_req_o = data_req_ex_i;          // straight through
        if (data_req_ex_i)
        begin
          lsu_ready_ex_o = data_gnt_i;       // stall EX until granted
          if (data_gnt_i)
            state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
        end
      end

      WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i;      // WB waits for the data
        if (data_rvalid_i)
        begin
          data_req_o = data_req_ex_i;        // next access may go out now
          if (data_req_ex_i)
          begin
            lsu_ready_ex_o = data_gnt_i;
            if (data_gnt_i)
              state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
            else
              state_d = IDLE;                // retry the request from IDLE
          end
          else
          begin
            state_d = IDLE;
          end
        end
      end

      // EX was stalled at grant and gets no new request until it moves
      WAIT_RVALID_EX_STALL:
      begin
        if (data_rvalid_i)
          state_d = ex_valid_i ? IDLE : IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = WAIT_RVALID;             // stall gone so wait normally
      end

      IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = IDLE;                    // data already held
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  assign busy_o = (state_q != IDLE) || data_req_o;

endmodule

// File: logic/lsu_pkg.sv
package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned DATA_W = 32;  // data and address width of one word
  localparam int unsigned BE_W   = 4;   // one byte enable per byte lane
  localparam int unsigned OFF_W  = 2;   // byte offset within a word
  localparam int unsigned TYPE_W = 2;   // data type field
  localparam int unsigned SEXT_W = 2;   // extension mode field

  ////////////////////////////////////////////////////////////
  // data type encodings
  ////////////////////////////////////////////////////////////

  // any type with the upper bit set is a byte access
  localparam logic [TYPE_W-1:0] TYPE_WORD = 2'd0;  // 32 bit access
  localparam logic [TYPE_W-1:0] TYPE_HALF = 2'd1;  // 16 bit access

  ////////////////////////////////////////////////////////////
  // extension mode encodings
  ////////////////////////////////////////////////////////////

  // every mode not listed here means sign extension
  localparam logic [SEXT_W-1:0] SEXT_ZERO = 2'd0;  // fill with zeros
  localparam logic [SEXT_W-1:0] SEXT_ONES = 2'd2;  // fill with ones

endpackage

// File: logic/lsu_rdata_align.sv
`timescale 1ns/1ps

module lsu_rdata_align
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       data_gnt_i,       // request accepted this cycle
  input  logic                       data_rvalid_i,    // read data valid this cycle
  input  logic [lsu_pkg::DATA_W-1:0] data_rdata_i,
  output logic [lsu_pkg::DATA_W-1:0] data_rdata_ex_o,  // aligned and extended result
  lsu_access_if.align                acc
);

  logic [lsu_pkg::TYPE_W-1:0] type_q;      // type of the outstanding access
  logic [lsu_pkg::OFF_W-1:0]  offset_q;    // its byte offset
  logic [lsu_pkg::SEXT_W-1:0] sext_q;      // its extension mode
  logic                       we_q;        // it was a store

  logic [lsu_pkg::DATA_W-1:0] rdata_q;     // first beat or last result
  logic [15:0]                half_sel;    // selected halfword
  logic [7:0]                 byte_sel;    // selected byte
  logic [lsu_pkg::DATA_W-1:0] rdata_w_ext;
  logic [lsu_pkg::DATA_W-1:0] rdata_h_ext;
  logic [lsu_pkg::DATA_W-1:0] rdata_b_ext;
  logic [lsu_pkg::DATA_W-1:0] rdata_ext;

  // fills bits at and above width as the mode asks
  function automatic logic [lsu_pkg::DATA_W-1:0] extend
  (
    input logic [lsu_pkg::DATA_W-1:0] val,    // field with zeros above width
    input int unsigned                width,  // field width in bits
    input logic [lsu_pkg::SEXT_W-1:0] mode
  );
    logic [lsu_pkg::DATA_W-1:0] fill;
    logic                       msb;
    fill = '1 << width;                       // ones above the field
    msb  = val[width-1];
    case (mode)
      lsu_pkg::SEXT_ZERO: extend = val;
      lsu_pkg::SEXT_ONES: extend = val | fill;
      default:            extend = msb ? (val | fill) : val;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // access context, captured on grant
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q   <= '0;
      offset_q <= '0;
      sext_q   <= '0;
      we_q     <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      type_q   <= acc.data_type;
      offset_q <= acc.offset;
      sext_q   <= acc.sign_ext;
      we_q     <= acc.we;
    end
  end

  ////////////////////////////////////////////////////////////
  // word, half and byte views
  ////////////////////////////////////////////////////////////

  // split word takes its low bytes from the held first beat
  always_comb
  begin
    case (offset_q)
      2'd0:    rdata_w_ext = data_rdata_i;
      2'd1:    rdata_w_ext = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'd2:    rdata_w_ext = {data_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w_ext = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (offset_q)
      2'd0:    half_sel = data_rdata_i[15:0];
      2'd1:    half_sel = data_rdata_i[23:8];
      2'd2:    half_sel = data_rdata_i[31:16];
      default: half_sel = {data_rdata_i[7:0], rdata_q[31:24]};  // crosses the boundary
    endcase
  end

  assign byte_sel = data_rdata_i[8*offset_q +: 8];  // bytes never cross

  assign rdata_h_ext = extend({{(lsu_pkg::DATA_W-16){1'b0}}, half_sel}, 16, sext_q);
  assign rdata_b_ext = extend({{(lsu_pkg::DATA_W-8){1'b0}}, byte_sel}, 8, sext_q);

  always_comb
  begin
    case (type_q)
      lsu_pkg::TYPE_WORD: rdata_ext = rdata_w_ext;
      lsu_pkg::TYPE_HALF: rdata_ext = rdata_h_ext;
      default:            rdata_ext = rdata_b_ext;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // hold register
  ////////////////////////////////////////////////////////////

  // keeps the raw beat while a split access runs and the final value otherwise
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (data_rvalid_i && !we_q)
    begin
      if (acc.split_pending)
        rdata_q <= data_rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;  // bypass on rvalid

endmodule

// File: logic/lsu_req_gen.sv
`timescale 1ns/1ps

module lsu_req_gen
(
  input  logic [lsu_pkg::DATA_W-1:0] operand_a_ex_i,        // base register
  input  logic [lsu_pkg::DATA_W-1:0] operand_b_ex_i,        // offset or increment
  input  logic [lsu_pkg::DATA_W-1:0] data_wdata_ex_i,       // store data from EX
  input  logic                       addr_useincr_ex_i,     // a + b when high, a alone when low
  input  logic                       data_req_ex_i,
  input  logic                       data_we_ex_i,
  input  logic                       data_misaligned_ex_i,  // second part of a split access
  input  logic [lsu_pkg::TYPE_W-1:0] data_type_ex_i,
  input  logic [lsu_pkg::OFF_W-1:0]  data_reg_offset_ex_i,  // byte position inside the register
  input  logic [lsu_pkg::SEXT_W-1:0] data_sign_ext_ex_i,
  output logic [lsu_pkg::DATA_W-1:0] data_addr_o,
  output logic [lsu_pkg::DATA_W-1:0] data_wdata_o,
  output logic [lsu_pkg::BE_W-1:0]   data_be_o,
  output logic                       data_misaligned_o,     // first part needs a second access
  lsu_access_if.req                  acc
);

  logic [lsu_pkg::OFF_W-1:0] addr_off;     // byte offset of the address
  logic [lsu_pkg::OFF_W-1:0] wdata_off;    // lane distance for store data

  ////////////////////////////////////////////////////////////
  // address
  ////////////////////////////////////////////////////////////

  assign data_addr_o = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i)
                                         : operand_a_ex_i;
  assign addr_off    = data_addr_o[lsu_pkg::OFF_W-1:0];

  ////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (data_type_ex_i)
      lsu_pkg::TYPE_WORD:
      begin
        if (!data_misaligned_ex_i)
        begin
          // first part covers offset up to the top lane
          case (addr_off)
            2'd0:    data_be_o = 4'b1111;
            2'd1:    data_be_o = 4'b1110;
            2'd2:    data_be_o = 4'b1100;
            default: data_be_o = 4'b1000;
          endcase
        end
        else
        begin
          // second part takes the leftover low lanes
          case (addr_off)
            2'd0:    data_be_o = 4'b0000;  // never split at offset 0
            2'd1:    data_be_o = 4'b0001;
            2'd2:    data_be_o = 4'b0011;
            default: data_be_o = 4'b0111;
          endcase
        end
      end

      lsu_pkg::TYPE_HALF:
      begin
        if (!data_misaligned_ex_i)
        begin
          case (addr_off)
            2'd0:    data_be_o = 4'b0011;
            2'd1:    data_be_o = 4'b0110;
            2'd2:    data_be_o = 4'b1100;
            default: data_be_o = 4'b1000;  // upper half goes in the second part
          endcase
        end
        else
        begin
          data_be_o = 4'b0001;             // only lane 0 is left
        end
      end

      default:                             // byte
      begin
        data_be_o = 4'b0001 << addr_off;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////////////////////////

  // moves the register byte at reg offset onto the lane of the address
  assign wdata_off = addr_off - data_reg_offset_ex_i;

  always_comb
  begin
    case (wdata_off)
      2'd0:    data_wdata_o = data_wdata_ex_i;
      2'd1:    data_wdata_o = {data_wdata_ex_i[23:0], data_wdata_ex_i[31:24]};
      2'd2:    data_wdata_o = {data_wdata_ex_i[15:0], data_wdata_ex_i[31:16]};
      default: data_wdata_o = {data_wdata_ex_i[7:0],  data_wdata_ex_i[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // misalignment detection
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i)  // first part only
    begin
      if ((data_type_ex_i == lsu_pkg::TYPE_WORD) && (addr_off != 2'd0))
        data_misaligned_o = 1'b1;                // word spills into next word
      if ((data_type_ex_i == lsu_pkg::TYPE_HALF) && (addr_off == 2'd3))
        data_misaligned_o = 1'b1;                // half crosses the boundary
    end
  end

  // context for the read data path
  assign acc.data_type     = data_type_ex_i;
  assign acc.offset        = addr_off;
  assign acc.sign_ext      = data_sign_ext_ex_i;
  assign acc.we            = data_we_ex_i;
  assign acc.split_pending = data_misaligned_ex_i | data_misaligned_o;

endmodule

// File: logic/lsu_top.sv
`timescale 1ns/1ps

module lsu_top
(
  input  logic                       clk,
  input  logic                       rst_n,

  // memory port
  output logic                       data_req_o,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  output logic [lsu_pkg::DATA_W-1:0] data_addr_o,
  output logic                       data_we_o,
  output logic [lsu_pkg::BE_W-1:0]   data_be_o,
  output logic [lsu_pkg::DATA_W-1:0] data_wdata_o,
  input  logic [lsu_pkg::DATA_W-1:0] data_rdata_i,

  // EX stage
  input  logic                       data_we_ex_i,
  input  logic [lsu_pkg::TYPE_W-1:0] data_type_ex_i,
  input  logic [lsu_pkg::DATA_W-1:0] data_wdata_ex_i,
  input  logic [lsu_pkg::OFF_W-1:0]  data_reg_offset_ex_i,
  input  logic [lsu_pkg::SEXT_W-1:0] data_sign_ext_ex_i,
  output logic [lsu_pkg::DATA_W-1:0] data_rdata_ex_o,
  input  logic                       data_req_ex_i,
  input  logic [lsu_pkg::DATA_W-1:0] operand_a_ex_i,
  input  logic [lsu_pkg::DATA_W-1:0] operand_b_ex_i,
  input  logic                       addr_useincr_ex_i,
  input  logic                       data_misaligned_ex_i,
  output logic                       data_misaligned_o,

  // pipeline control
  output logic                       lsu_ready_ex_o,
  output logic                       lsu_ready_wb_o,
  input  logic                       ex_valid_i,
  output logic                       busy_o
);

  lsu_access_if acc ();  // context from request to read data

  assign data_we_o = data_we_ex_i;

  lsu_req_gen i_lsu_req_gen
  (
    .operand_a_ex_i       (operand_a_ex_i),
    .operand_b_ex_i       (operand_b_ex_i),
    .data_wdata_ex_i      (data_wdata_ex_i),
    .addr_useincr_ex_i    (addr_useincr_ex_i),
    .data_req_ex_i        (data_req_ex_i),
    .data_we_ex_i         (data_we_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_type_ex_i       (data_type_ex_i),
    .data_reg_offset_ex_i (data_reg_offset_ex_i),
    .data_sign_ext_ex_i   (data_sign_ext_ex_i),
    .data_addr_o          (data_addr_o),
    .data_wdata_o         (data_wdata_o),
    .data_be_o            (data_be_o),
    .data_misaligned_o    (data_misaligned_o),
    .acc                  (acc.req)
  );

  lsu_rdata_align i_lsu_rdata_align
  (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_rdata_i    (data_rdata_i),
    .data_rdata_ex_o (data_rdata_ex_o),
    .acc             (acc.align)
  );

  lsu_ctrl_fsm i_lsu_ctrl_fsm
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .ex_valid_i     (ex_valid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

endmodule

// File: verilog.f
logic/lsu_pkg.sv
logic/lsu_access_if.sv
logic/lsu_req_gen.sv
logic/lsu_rdata_align.sv
logic/lsu_ctrl_fsm.sv
logic/lsu_top.sv
dv/tb_lsu.sv
